/* Makefile */
TOP := usb_tx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -sv --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

lint:
	verilator --lint-only -Wall -sv --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* logic/usb_fs_tx.sv */
// USB full-speed serializer
// SYNC/PID/data/CRC16/EOP sequencing, bit stuffing, NRZI, line output flops

`timescale 1ns/1ps

module usb_fs_tx
  import usb_tx_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cfg_pinflip_i,
  input  logic      tx_osc_test_mode_i,
  input  logic      bit_strobe_i,
  input  logic      pkt_start_i,
  output logic      pkt_end_o,
  input  usb_pid_t  pid_i,
  input  logic      tx_data_avail_i,
  output logic      tx_data_get_o,
  input  usb_byte_t tx_data_i,
  output logic      usb_oe_o,
  output logic      usb_d_o,
  output logic      usb_se0_o,
  output logic      usb_dp_o,
  output logic      usb_dn_o
);

  localparam usb_byte_t   SyncByte  = 8'h80;
  localparam logic [15:0] Crc16Poly = 16'h8005;

  tx_state_e   state_q, state_d;
  out_state_e  out_state_q, out_state_d;

  // Per-bit data, output enable and SE0 shifters, LSB goes out first
  usb_byte_t   data_sr_q, data_sr_d;
  usb_byte_t   oe_sr_q, oe_sr_d;
  usb_byte_t   se0_sr_q, se0_sr_d;
  logic [4:0]  history_q, history_d;
  logic [5:0]  history;
  logic [2:0]  bit_cnt_q, bit_cnt_d;
  logic        byte_strobe_q, byte_strobe_d;
  logic        payload_q, payload_d;
  logic        get_d;
  logic        stuffed_q;
  logic [15:0] crc_q, crc_d;
  logic        bitstuff;
  logic        ser_data;
  logic        ser_oe;
  logic        ser_se0;
  logic        nrzi_en;
  logic        d_q, d_d;
  logic        se0_q, se0_d;
  logic        oe_d;
  logic [2:0]  eop_q, eop_d;
  logic        dp_next;
  logic        dn_next;

  function automatic usb_byte_t rev8(input usb_byte_t b);
    usb_byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7 - i];
    end
    return r;
  endfunction

  assign ser_data = data_sr_q[0];
  assign ser_oe   = oe_sr_q[0];
  assign ser_se0  = se0_sr_q[0];

  // Six ones in a row including the bit now on the line
  assign history  = {ser_data, history_q};
  assign bitstuff = (history == 6'b111111);

  // Final J bit of the EOP
  assign pkt_end_o = bit_strobe_i && (se0_sr_q[1:0] == 2'b01);

  //////////////////////////////////////////////////////////////////////
  // Byte sequencing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    data_sr_d = data_sr_q;
    oe_sr_d   = oe_sr_q;
    se0_sr_d  = se0_sr_q;
    payload_d = payload_q;
    history_d = history_q;
    bit_cnt_d = bit_cnt_q;
    get_d     = 1'b0;

    unique case (state_q)
      Idle: begin
        if (tx_osc_test_mode_i) begin
          state_d = OscTest;
        end else if (pkt_start_i) begin
          state_d = Sync;
        end
      end
      Sync: begin
        if (byte_strobe_q) begin
          state_d   = Pid;
          data_sr_d = SyncByte;
          oe_sr_d   = 8'hff;
          se0_sr_d  = 8'h00;
        end
      end
      Pid: begin
        if (byte_strobe_q) begin
          state_d   = (pid_i[1:0] == 2'b11) ? DataOrCrc160 : Eop;
          data_sr_d = {~pid_i, pid_i};
          oe_sr_d   = 8'hff;
          se0_sr_d  = 8'h00;
        end
      end
      DataOrCrc160: begin
        if (byte_strobe_q) begin
          oe_sr_d  = 8'hff;
          se0_sr_d = 8'h00;
          if (tx_data_avail_i) begin
            payload_d = 1'b1;
            get_d     = 1'b1;
            data_sr_d = tx_data_i;
          end else begin
            state_d   = Crc161;
            payload_d = 1'b0;
            data_sr_d = ~rev8(crc_q[15:8]);
          end
        end
      end
      Crc161: begin
        if (byte_strobe_q) begin
          state_d   = Eop;
          data_sr_d = ~rev8(crc_q[7:0]);
          oe_sr_d   = 8'hff;
          se0_sr_d  = 8'h00;
        end
      end
      Eop: begin
        // SE0, SE0, J
        if (byte_strobe_q) begin
          state_d  = Idle;
          oe_sr_d  = 8'h07;
          se0_sr_d = 8'h07;
        end
      end
      OscTest: begin
        if (!tx_osc_test_mode_i) begin
          state_d = pkt_start_i ? Sync : Idle;
          oe_sr_d = 8'h00;
        end else if (byte_strobe_q) begin
          // All zeros toggle the line every bit
          data_sr_d = 8'h00;
          oe_sr_d   = 8'hff;
        end
      end
      default: state_d = Idle;
    endcase

    // One bit time of gap before SYNC
    if (pkt_start_i) begin
      bit_cnt_d = 3'd7;
      history_d = '0;
    end else if (bit_strobe_i) begin
      history_d = history[5:1];
      if (bitstuff) begin
        // The sent one's slot is reused for the stuffed zero
        data_sr_d[0] = 1'b0;
      end else begin
        bit_cnt_d = bit_cnt_q + 3'd1;
        data_sr_d = data_sr_q >> 1;
        oe_sr_d   = oe_sr_q >> 1;
        se0_sr_d  = se0_sr_q >> 1;
      end
    end
  end

  assign byte_strobe_d = bit_strobe_i && !bitstuff && !pkt_start_i && (bit_cnt_q == 3'd0);

  // CRC16 over payload bits, stuffed zeros excluded
  always_comb begin
    crc_d = crc_q;
    if (pkt_start_i) begin
      crc_d = '1;
    end else if (bit_strobe_i && payload_q && !stuffed_q) begin
      crc_d = {crc_q[14:0], 1'b0} ^ ((ser_data ^ crc_q[15]) ? Crc16Poly : 16'h0000);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      history_q     <= '0;
      bit_cnt_q     <= '0;
      byte_strobe_q <= 1'b0;
      payload_q     <= 1'b0;
      tx_data_get_o <= 1'b0;
      stuffed_q     <= 1'b0;
      crc_q         <= '0;
    end else begin
      state_q       <= state_d;
      data_sr_q     <= data_sr_d;
      oe_sr_q       <= oe_sr_d;
      se0_sr_q      <= se0_sr_d;
      history_q     <= history_d;
      bit_cnt_q     <= bit_cnt_d;
      byte_strobe_q <= byte_strobe_d;
      payload_q     <= payload_d;
      tx_data_get_o <= get_d;
      crc_q         <= crc_d;
      if (bit_strobe_i) begin
        stuffed_q <= bitstuff;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // NRZI and line drivers
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    out_state_d = out_state_q;
    nrzi_en     = 1'b0;
    unique case (out_state_q)
      // Level check, the previous packet may still be in its idle bit
      OsIdle: begin
        if (state_q inside {Sync, OscTest}) begin
          out_state_d = OsWaitByte;
        end
      end
      OsWaitByte: begin
        if (byte_strobe_q) begin
          out_state_d = OsTransmit;
        end
      end
      OsTransmit: begin
        nrzi_en = 1'b1;
        if (bit_strobe_i && !ser_oe) begin
          out_state_d = OsIdle;
        end
      end
      default: out_state_d = OsIdle;
    endcase
  end

  always_comb begin
    d_d   = d_q;
    se0_d = se0_q;
    oe_d  = usb_oe_o;
    eop_d = eop_q;
    if (pkt_start_i) begin
      // Start from J so the first SYNC bit is K
      d_d   = 1'b1;
      eop_d = 3'b100;
    end else if (bit_strobe_i && nrzi_en) begin
      oe_d = ser_oe;
      if (ser_se0) begin
        eop_d = eop_q >> 1;
        if (eop_q[0]) begin
          d_d   = 1'b1;
          se0_d = 1'b0;
        end else begin
          se0_d = 1'b1;
        end
      end else if (!ser_data) begin
        d_d = ~d_q;
      end
      // Park in J while released
      if (!oe_d) begin
        d_d = 1'b1;
      end
    end
  end

  assign dp_next = (cfg_pinflip_i ? ~d_d :  d_d) & ~se0_d;
  assign dn_next = (cfg_pinflip_i ?  d_d : ~d_d) & ~se0_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_state_q <= OsIdle;
      eop_q       <= '0;
      d_q         <= 1'b1;
      se0_q       <= 1'b0;
      usb_oe_o    <= 1'b0;
      usb_d_o     <= 1'b1;
      usb_se0_o   <= 1'b0;
      usb_dp_o    <= 1'b1;
      usb_dn_o    <= 1'b0;
    end else begin
      out_state_q <= out_state_d;
      eop_q       <= eop_d;
      d_q         <= d_d;
      se0_q       <= se0_d;
      usb_oe_o    <= oe_d;
      // Single-ended D follows D+ after the flip
      usb_d_o     <= dp_next;
      usb_se0_o   <= se0_d;
      usb_dp_o    <= dp_next;
      usb_dn_o    <= dn_next;
    end
  end

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {Idle, Sync, Pid, DataOrCrc160, Crc161, Eop, OscTest});

  a_out_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_state_q inside {OsIdle, OsWaitByte, OsTransmit});

endmodule

/* logic/usb_tx_cfg.sv */
// Configuration registers of the USB transmitter
// Control bits, sent packet counter and host readback mux

`timescale 1ns/1ps

`include "usb_tx_macros.svh"

module usb_tx_cfg
  import usb_tx_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        cfg_we_i,
  input  logic        cfg_addr_i,
  input  usb_byte_t   cfg_wdata_i,
  output logic [15:0] cfg_rdata_o,
  input  logic        pkt_done_i,
  output usb_tx_cfg_t cfg_o
);

  usb_tx_cfg_t ctrl_q;
  pkt_cnt_t    count_q;
  logic        ctrl_sel;

  assign ctrl_sel = (cfg_addr_i == 1'(`USB_TX_CFG_ADDR_CTRL));

  // Control bits: 0 enable, 1 pinflip, 2 osc_test
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q  <= '0;
      count_q <= '0;
    end else begin
      if (cfg_we_i && ctrl_sel) begin
        ctrl_q.enable   <= cfg_wdata_i[0];
        ctrl_q.pinflip  <= cfg_wdata_i[1];
        ctrl_q.osc_test <= cfg_wdata_i[2];
      end
      // Wraps silently at 16 bits
      if (pkt_done_i) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_comb begin
    cfg_rdata_o = '0;
    if (ctrl_sel) begin
      cfg_rdata_o[2:0] = {ctrl_q.osc_test, ctrl_q.pinflip, ctrl_q.enable};
    end else if (cfg_addr_i == 1'(`USB_TX_CFG_ADDR_COUNT)) begin
      cfg_rdata_o = count_q;
    end
  end

  assign cfg_o = ctrl_q;

endmodule

/* logic/usb_tx_fifo.sv */
// Host packet buffer of the USB transmitter
// Circular word store, credit return and complete-packet count

`timescale 1ns/1ps

`include "usb_tx_macros.svh"

module usb_tx_fifo
  import usb_tx_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  tx_word_t push_word_i,
  input  logic     pop_i,
  output tx_word_t head_o,
  output logic     head_valid_o,
  output logic     pkt_ready_o,
  output logic     credit_o
);

  localparam int Depth = `USB_TX_FIFO_DEPTH;
  localparam int PtrW  = $clog2(Depth);
  localparam logic [PtrW-1:0] PtrLast = PtrW'(Depth - 1);

  tx_word_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  fifo_cnt_t       count_q;
  fifo_cnt_t       pkts_q;
  logic            pkt_in;
  logic            pkt_out;

  assign pkt_in  = push_i && push_word_i.last;
  assign pkt_out = pop_i && head_o.last;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      pkts_q   <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrLast) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrLast) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + fifo_cnt_t'(push_i) - fifo_cnt_t'(pop_i);
      pkts_q   <= pkts_q + fifo_cnt_t'(pkt_in) - fifo_cnt_t'(pkt_out);
      // One credit back per word that left
      credit_o <= pop_i;
    end
  end

  assign head_o       = mem_q[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  assign pkt_ready_o  = (pkts_q != '0);

  // Host must respect its credits
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && count_q == fifo_cnt_t'(Depth)));

  // Controller only pops stored words
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> count_q != '0);

endmodule

/* logic/usb_tx_macros.svh */
// Build-time constants of the USB full-speed transmitter
// Packet buffer depth, bit strobe divider and config register map

`ifndef USB_TX_MACROS_SVH
`define USB_TX_MACROS_SVH

// Words held by the host packet buffer
`define USB_TX_FIFO_DEPTH 16

// Clocks per bit, 48 MHz down to 12 Mbit/s
`define USB_TX_STROBE_DIV 4

// Config port register map
`define USB_TX_CFG_ADDR_CTRL  0
`define USB_TX_CFG_ADDR_COUNT 1

`endif

/* logic/usb_tx_pkg.sv */
// Shared types of the USB full-speed transmitter
// Vector typedefs, host word and config structs, serializer FSM states

`include "usb_tx_macros.svh"

package usb_tx_pkg;

  typedef logic [7:0]  usb_byte_t;
  typedef logic [3:0]  usb_pid_t;
  typedef logic [15:0] pkt_cnt_t;

  // Wide enough for a completely full buffer
  typedef logic [$clog2(`USB_TX_FIFO_DEPTH + 1) - 1:0] fifo_cnt_t;

  // One word from the host, either a header (PID in data[3:0]) or a payload byte
  typedef struct packed {
    logic      is_header;
    logic      last;
    usb_byte_t data;
  } tx_word_t;

  typedef struct packed {
    logic enable;
    logic pinflip;
    logic osc_test;
  } usb_tx_cfg_t;

  // Byte level sequencing of a packet
  typedef enum logic [2:0] {
    Idle, Sync, Pid, DataOrCrc160, Crc161, Eop, OscTest
  } tx_state_e;

  // Line driver ownership
  typedef enum logic [1:0] {
    OsIdle, OsWaitByte, OsTransmit
  } out_state_e;

endpackage

/* logic/usb_tx_pkt_ctrl.sv */
// Packet controller of the USB transmitter
// Bit strobe divider, packet start sequencing and payload pops

`timescale 1ns/1ps

`include "usb_tx_macros.svh"

module usb_tx_pkt_ctrl
  import usb_tx_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  usb_tx_cfg_t cfg_i,
  input  tx_word_t    head_i,
  input  logic        head_valid_i,
  input  logic        pkt_ready_i,
  output logic        pop_o,
  output logic        bit_strobe_o,
  output logic        pkt_start_o,
  output usb_pid_t    pid_o,
  output logic        tx_data_avail_o,
  output usb_byte_t   tx_data_o,
  input  logic        tx_data_get_i,
  input  logic        pkt_end_i
);

  localparam int DivW = $clog2(`USB_TX_STROBE_DIV);
  localparam logic [DivW-1:0] DivLast = DivW'(`USB_TX_STROBE_DIV - 1);

  logic [DivW-1:0] div_q;
  logic            busy_q;
  logic            start;

  // Only a fully buffered packet may start
  assign start = pkt_ready_i && head_valid_i && head_i.is_header && cfg_i.enable &&
                 !cfg_i.osc_test && !busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_q        <= '0;
      bit_strobe_o <= 1'b0;
      busy_q       <= 1'b0;
      pkt_start_o  <= 1'b0;
      pid_o        <= '0;
    end else begin
      div_q        <= (div_q == DivLast) ? '0 : div_q + 1'b1;
      bit_strobe_o <= (div_q == DivLast);
      pkt_start_o  <= start;
      if (start) begin
        busy_q <= 1'b1;
        pid_o  <= head_i.data[3:0];
      end else if (pkt_end_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Header leaves on the start decision, payload bytes on each pull
  assign pop_o           = start || tx_data_get_i;
  assign tx_data_avail_o = busy_q && head_valid_i && !head_i.is_header;
  assign tx_data_o       = head_i.data;

  a_get_when_avail: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_data_get_i |-> tx_data_avail_o);

endmodule

/* logic/usb_tx_top.sv */
// Top level of the USB full-speed packet transmitter
// Config block, packet buffer, packet controller and serializer

`timescale 1ns/1ps

module usb_tx_top
  import usb_tx_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Host port
  input  tx_word_t    tx_word_i,
  input  logic        tx_valid_i,
  output logic        tx_credit_o,
  // Config port
  input  logic        cfg_we_i,
  input  logic        cfg_addr_i,
  input  usb_byte_t   cfg_wdata_i,
  output logic [15:0] cfg_rdata_o,
  // USB bus
  output logic        usb_oe_o,
  output logic        usb_d_o,
  output logic        usb_se0_o,
  output logic        usb_dp_o,
  output logic        usb_dn_o
);

  usb_tx_cfg_t cfg;
  tx_word_t    head;
  logic        head_valid;
  logic        pkt_ready;
  logic        pop;
  logic        bit_strobe;
  logic        pkt_start;
  logic        pkt_end;
  usb_pid_t    pid;
  logic        tx_data_avail;
  logic        tx_data_get;
  usb_byte_t   tx_data;

  usb_tx_cfg u_cfg (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .pkt_done_i  (pkt_end),
    .cfg_o       (cfg)
  );

  usb_tx_fifo u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (tx_valid_i),
    .push_word_i  (tx_word_i),
    .pop_i        (pop),
    .head_o       (head),
    .head_valid_o (head_valid),
    .pkt_ready_o  (pkt_ready),
    .credit_o     (tx_credit_o)
  );

  usb_tx_pkt_ctrl u_pkt_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cfg_i           (cfg),
    .head_i          (head),
    .head_valid_i    (head_valid),
    .pkt_ready_i     (pkt_ready),
    .pop_o           (pop),
    .bit_strobe_o    (bit_strobe),
    .pkt_start_o     (pkt_start),
    .pid_o           (pid),
    .tx_data_avail_o (tx_data_avail),
    .tx_data_o       (tx_data),
    .tx_data_get_i   (tx_data_get),
    .pkt_end_i       (pkt_end)
  );

  usb_fs_tx u_fs_tx (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .cfg_pinflip_i      (cfg.pinflip),
    .tx_osc_test_mode_i (cfg.osc_test),
    .bit_strobe_i       (bit_strobe),
    .pkt_start_i        (pkt_start),
    .pkt_end_o          (pkt_end),
    .pid_i              (pid),
    .tx_data_avail_i    (tx_data_avail),
    .tx_data_get_o      (tx_data_get),
    .tx_data_i          (tx_data),
    .usb_oe_o           (usb_oe_o),
    .usb_d_o            (usb_d_o),
    .usb_se0_o          (usb_se0_o),
    .usb_dp_o           (usb_dp_o),
    .usb_dn_o           (usb_dn_o)
  );

endmodule

/* project.f */
+incdir+logic
logic/usb_tx_pkg.sv
logic/usb_tx_cfg.sv
logic/usb_tx_fifo.sv
logic/usb_tx_pkt_ctrl.sv
logic/usb_fs_tx.sv
logic/usb_tx_top.sv
tests/usb_line_monitor.sv
tests/usb_tx_tb.sv

/* tests/usb_line_monitor.sv */
// Bus monitor for the USB transmitter testbench
// Mid-bit sampling, NRZI decode, unstuffing and EOP detection

`timescale 1ns/1ps

module usb_line_monitor (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  logic       flip_i,
  input  logic       dp_i,
  input  logic       dn_i,
  output logic       done_o,
  output logic [7:0] bytes_o [32],
  output int         len_o,
  output logic       err_o,
  output int         err_code_o
);

  logic [1:0] line_q;
  int         phase;
  logic       busy;
  logic       prev_j;
  int         ones;
  int         se0_n;
  int         bit_cnt;
  logic [7:0] sh;

  task flag_error(input int code);
    err_o      <= 1'b1;
    err_code_o <= code;
  endtask

  // One decoded bit, stuffed zeros dropped
  task take_bit(input logic b);
    if (ones == 6) begin
      if (b) begin
        flag_error(1);
      end
      ones = 0;
    end else begin
      ones    = b ? ones + 1 : 0;
      sh      = {b, sh[7:1]};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8) begin
        if (len_o >= 32) begin
          flag_error(4);
        end else begin
          bytes_o[len_o] <= sh;
        end
        len_o   = len_o + 1;
        bit_cnt = 0;
      end
    end
  endtask

  // Outputs are registered on the rising edge, so look on the falling one
  always @(negedge clk_i) begin
    logic j;
    logic se0;
    j      = flip_i ? (!dp_i && dn_i) : (dp_i && !dn_i);
    se0    = !dp_i && !dn_i;
    done_o <= 1'b0;
    if (!rst_ni || !en_i) begin
      busy   = 1'b0;
      phase  = 0;
      line_q = {dp_i, dn_i};
      if (!rst_ni) begin
        err_o      <= 1'b0;
        err_code_o <= 0;
        len_o      = 0;
      end
    end else begin
      // Resync the bit phase on every line change
      phase  = ({dp_i, dn_i} != line_q) ? 0 : (phase + 1) % 4;
      line_q = {dp_i, dn_i};
      if (phase == 2) begin
        if (!busy) begin
          if (se0) begin
            flag_error(3);
          end else if (!j) begin
            busy    = 1'b1;
            ones    = 0;
            se0_n   = 0;
            bit_cnt = 0;
            len_o   = 0;
            take_bit(1'b0);
            prev_j  = 1'b0;
          end
        end else if (se0) begin
          if (bit_cnt != 0 || ones == 6) begin
            flag_error(3);
          end
          se0_n = se0_n + 1;
        end else if (se0_n > 0) begin
          if (!j || se0_n != 2) begin
            flag_error(2);
          end
          busy   = 1'b0;
          done_o <= 1'b1;
        end else begin
          take_bit(j == prev_j);
          prev_j = j;
        end
      end
    end
  end

endmodule

/* tests/usb_tx_tb.sv */
// Testbench of the USB full-speed transmitter
// Random packets from an LCG, credit and CRC16 models, bus checks

`timescale 1ns/1ps

`include "usb_tx_macros.svh"

module usb_tx_tb
  import usb_tx_pkg::*;
();

  localparam int NumPktA  = 30;
  localparam int NumPktB  = 20;
  localparam int NumPktC  = 2;
  localparam int NumPkts  = NumPktA + NumPktB + NumPktC;
  localparam int CycLimit = 2000 * NumPkts + 1000;

  logic        clk_i;
  logic        rst_ni;
  tx_word_t    tx_word;
  logic        tx_valid;
  logic        tx_credit;
  logic        cfg_we;
  logic        cfg_addr;
  usb_byte_t   cfg_wdata;
  logic [15:0] cfg_rdata;
  logic        usb_oe;
  logic        usb_d;
  logic        usb_se0;
  logic        usb_dp;
  logic        usb_dn;

  logic        mon_en;
  logic        mon_flip;
  logic        mon_done;
  logic [7:0]  mon_bytes [32];
  int          mon_len;
  logic        mon_err;
  int          mon_err_code;

  logic [31:0] rand_state = 32'd87854;
  int          cycles = 0;
  int          pushed = 0;
  int          returned = 0;
  int          sent = 0;
  int          received = 0;
  usb_byte_t   exp_bytes [$];
  int          exp_len [$];

  usb_tx_top dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tx_word_i   (tx_word),
    .tx_valid_i  (tx_valid),
    .tx_credit_o (tx_credit),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata),
    .usb_oe_o    (usb_oe),
    .usb_d_o     (usb_d),
    .usb_se0_o   (usb_se0),
    .usb_dp_o    (usb_dp),
    .usb_dn_o    (usb_dn)
  );

  usb_line_monitor u_mon (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .en_i       (mon_en),
    .flip_i     (mon_flip),
    .dp_i       (usb_dp),
    .dn_i       (usb_dn),
    .done_o     (mon_done),
    .bytes_o    (mon_bytes),
    .len_o      (mon_len),
    .err_o      (mon_err),
    .err_code_o (mon_err_code)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return {16'h0, rand_state[30:15]};
  endfunction

  // USB CRC16 in its reflected form, poly 0x8005 reversed is 0xa001
  function automatic logic [15:0] crc16(input usb_byte_t b [$]);
    logic [15:0] c;
    c = 16'hffff;
    foreach (b[i]) begin
      c[7:0] = c[7:0] ^ b[i];
      for (int k = 0; k < 8; k++) begin
        c = c[0] ? ((c >> 1) ^ 16'ha001) : (c >> 1);
      end
    end
    return c;
  endfunction

  task wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task cfg_read(input logic addr, output logic [15:0] data);
    cfg_addr = addr;
    #1;
    data = cfg_rdata;
  endtask

  // Control writes are read back at address 0
  task cfg_write(input logic addr, input usb_byte_t data);
    logic [15:0] rd;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    @(negedge clk_i);
    cfg_we    = 1'b0;
    if (addr == 1'b0) begin
      cfg_read(1'b0, rd);
      assert (rd == {13'h0, data[2:0]}) else
        fail_run($sformatf("** Error cfg_rdata_o: got %h exp %h", rd, {13'h0, data[2:0]}));
    end
  endtask

  // Spend one credit, then leave a random gap
  task push_word(input tx_word_t w);
    int gap;
    while (`USB_TX_FIFO_DEPTH - pushed + returned <= 0) begin
      @(negedge clk_i);
    end
    tx_word  = w;
    tx_valid = 1'b1;
    pushed   = pushed + 1;
    @(negedge clk_i);
    tx_valid = 1'b0;
    gap      = next_rand() % 4;
    wait_cycles(gap);
  endtask

  task automatic send_packet(input int max_len);
    usb_pid_t    pid;
    logic        is_data;
    logic        all_ff;
    int          n;
    usb_byte_t   pl [$];
    logic [15:0] c;
    logic [31:0] r;
    r       = next_rand();
    pid     = (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
    is_data = (pid[1:0] == 2'b11);
    n       = is_data ? int'(r[11:4]) % (max_len + 1) : 0;
    all_ff  = (r[13:12] == 2'b00);
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      pl.push_back(all_ff ? 8'hff : r[7:0]);
    end
    exp_bytes.push_back(8'h80);
    exp_bytes.push_back({~pid, pid});
    foreach (pl[i]) begin
      exp_bytes.push_back(pl[i]);
    end
    if (is_data) begin
      // Low byte of the reflected remainder goes first
      c = ~crc16(pl);
      exp_bytes.push_back(c[7:0]);
      exp_bytes.push_back(c[15:8]);
    end
    exp_len.push_back(is_data ? n + 4 : 2);
    sent = sent + 1;
    push_word('{is_header: 1'b1, last: (n == 0), data: {4'h0, pid}});
    for (int i = 0; i < n; i++) begin
      push_word('{is_header: 1'b0, last: (i == n - 1), data: pl[i]});
    end
  endtask

  // Everything out on the bus and every credit back
  task wait_drained();
    while (received < sent || returned < pushed) begin
      @(negedge clk_i);
    end
    wait_cycles(8);
    assert (returned == pushed) else
      fail_run($sformatf("** Error credits: got %h exp %h", returned, pushed));
  endtask

  task check_idle_line(input logic flip);
    assert (usb_oe == 1'b0) else fail_run($sformatf("** Error usb_oe: got %h exp 0", usb_oe));
    assert ({usb_dp, usb_dn} == (flip ? 2'b01 : 2'b10)) else
      fail_run($sformatf("** Error {usb_dp,usb_dn}: got %h exp %h", {usb_dp, usb_dn},
                         flip ? 2'b01 : 2'b10));
  endtask

  task check_osc_test();
    logic [15:0] cnt_before;
    logic [15:0] cnt_after;
    logic        prev_dp;
    int          last;
    mon_en = 1'b0;
    cfg_read(1'b1, cnt_before);
    cfg_write(1'b0, 8'h05);
    while (!usb_oe) begin
      @(negedge clk_i);
    end
    // Both packets must fit in the buffer while nothing drains
    for (int i = 0; i < NumPktC; i++) begin
      send_packet(6);
    end
    prev_dp = usb_dp;
    last    = -1;
    for (int i = 0; i < 120; i++) begin
      @(negedge clk_i);
      assert (usb_oe) else fail_run($sformatf("** Error usb_oe: got %h exp 1", usb_oe));
      if (usb_dp != prev_dp) begin
        assert (last < 0 || i - last == 4) else
          fail_run($sformatf("** Error toggle interval: got %h exp 4", i - last));
        last    = i;
        prev_dp = usb_dp;
      end
    end
    assert (last >= 0) else fail_run("The line did not toggle in oscillator test mode");
    cfg_read(1'b1, cnt_after);
    assert (cnt_after == cnt_before) else
      fail_run($sformatf("** Error count: got %h exp %h", cnt_after, cnt_before));
    // Leave the mode with the transmitter disabled so the monitor can rejoin first
    cfg_write(1'b0, 8'h00);
    while (usb_oe) begin
      @(negedge clk_i);
    end
    wait_cycles(4);
    mon_en = 1'b1;
    cfg_write(1'b0, 8'h01);
  endtask

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > CycLimit) begin
      fail_run("Timeout before all packets were sent");
    end
  end

  always @(posedge clk_i) begin
    if (tx_credit) begin
      returned = returned + 1;
    end
    assert (pushed - returned >= 0) else
      fail_run("More credits came back than words were pushed");
    assert (!mon_err) else
      fail_run($sformatf("Bus monitor error %0d (1 stuff, 2 EOP, 3 SE0, 4 length)",
                         mon_err_code));
  end

  // Single-ended outputs follow the pair
  always @(negedge clk_i) begin
    if (rst_ni) begin
      assert (usb_se0 == (!usb_dp && !usb_dn)) else
        fail_run($sformatf("** Error usb_se0: got %h exp %h", usb_se0, !usb_dp && !usb_dn));
      assert (!(usb_dp && usb_dn)) else fail_run("Both bus lines were driven high");
      assert (usb_se0 || usb_d == usb_dp) else
        fail_run($sformatf("** Error usb_d: got %h exp %h", usb_d, usb_dp));
    end
  end

  // Compare each received packet with the oldest expected one
  always @(posedge clk_i) begin
    int n;
    if (mon_done) begin
      assert (exp_len.size() > 0) else fail_run("A packet appeared with none expected");
      n = exp_len.pop_front();
      assert (mon_len == n) else
        fail_run($sformatf("** Error mon_len: got %h exp %h", mon_len, n));
      for (int i = 0; i < n; i++) begin
        assert (mon_bytes[i] == exp_bytes[0]) else
          fail_run($sformatf("** Error byte[%0d]: got %h exp %h", i, mon_bytes[i],
                             exp_bytes[0]));
        void'(exp_bytes.pop_front());
      end
      received = received + 1;
    end
  end

  initial begin
    logic [15:0] rd;
    rst_ni    = 1'b0;
    tx_word   = '0;
    tx_valid  = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = 1'b0;
    cfg_wdata = '0;
    mon_en    = 1'b0;
    mon_flip  = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    wait_cycles(2);
    check_idle_line(1'b0);
    mon_en = 1'b1;
    cfg_write(1'b0, 8'h01);

    for (int i = 0; i < NumPktA; i++) begin
      send_packet(12);
    end
    wait_drained();
    check_idle_line(1'b0);

    mon_en = 1'b0;
    cfg_write(1'b0, 8'h03);
    mon_flip = 1'b1;
    wait_cycles(10);
    mon_en = 1'b1;
    for (int i = 0; i < NumPktB; i++) begin
      send_packet(12);
    end
    wait_drained();
    check_idle_line(1'b1);

    mon_flip = 1'b0;
    check_osc_test();
    wait_drained();
    check_idle_line(1'b0);

    cfg_read(1'b1, rd);
    assert (rd == 16'(sent)) else
      fail_run($sformatf("** Error cfg_rdata_o: got %h exp %h", rd, 16'(sent)));
    $display("Result: PASSED");
    $finish;
  end

endmodule
